// File: tb.f
interleave_pkg.sv
bank_if.sv
bank_fifo.sv
interleave_writer.sv
interleave_reader.sv
stream_out_fifo.sv
interleave_top.sv
tb_interleave.sv

// File: Bender.yml
package:
  name: interleave

sources:
  - interleave_pkg.sv
  - bank_if.sv
  - bank_fifo.sv
  - interleave_writer.sv
  - interleave_reader.sv
  - stream_out_fifo.sv
  - interleave_top.sv
  - target: test
    files:
      - tb_interleave.sv

// File: tb_interleave.sv
// Interleaver testbench
// Random AXI-stream traffic through the block interleaver, checked beat by
// beat against the interleave order applied to a queue of accepted beats
`timescale 1ns/1ps
`default_nettype none

module tb_interleave import interleave_pkg::*; ();

  localparam int clk_period      = 10;
  localparam int hold_cycles     = 600;             // Output stall in test 5
  localparam int total_beats     = 11 * block_len;  // 3 + 1 + 4 + 3 blocks
  localparam int watchdog_cycles = 20 * total_beats + hold_cycles + 1000;

  logic              s_axis_aclk   = 1'b0;
  logic              rst           = 1'b1;
  logic              s_axis_tvalid = 1'b0;
  logic              s_axis_tready;
  logic [data_w-1:0] s_axis_tdata  = '0;
  logic [keep_w-1:0] s_axis_tkeep  = '0;
  logic              s_axis_tlast  = 1'b0;
  logic              m_axis_tvalid;
  logic              m_axis_tready = 1'b0;
  logic [data_w-1:0] m_axis_tdata;
  logic [keep_w-1:0] m_axis_tkeep;
  logic              m_axis_tlast;

  integer seed       = 32'hc52babb1;
  integer ready_seed = 32'hc52babb1 ^ 32'h0000ffff;  // Separate stream for m_axis_tready
  beat_t  sent_q [$];                                // Accepted input beats in order
  int     out_cnt    = 0;
  int     errors     = 0;
  int     checks     = 0;
  int     stall_cnt  = 0;
  int     beat_seq   = 0;
  int     ready_mode = 1;                            // 0 low, 1 high, 2 random

  always #(clk_period / 2) s_axis_aclk = ~s_axis_aclk;

  interleave_top dut_i (.*);

  //////////////////////////////
  // Model and compare tasks
  //////////////////////////////

  // Output beat k comes from bank k mod 8, entry (k / 8) mod 16 of its burst
  function automatic int expected_index(input int k);
    return (k % bank_count) * burst_len + (k / bank_count) % burst_len
           + block_len * (k / block_len);
  endfunction

  function automatic int rand_pct();
    return ($random(seed) & 32'h7fff_ffff) % 100;
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_beat(input int k, input beat_t got, input beat_t exp);
    checks++;
    if (got.data !== exp.data) begin
      $display("CHECK FAILED m_axis_tdata beat %0d: got %h expected %h", k, got.data, exp.data);
      errors++;
    end
    if (got.keep !== exp.keep) begin
      $display("CHECK FAILED m_axis_tkeep beat %0d: got %h expected %h", k, got.keep, exp.keep);
      errors++;
    end
    if (got.last !== exp.last) begin
      $display("CHECK FAILED m_axis_tlast beat %0d: got %h expected %h", k, got.last, exp.last);
      errors++;
    end
  endtask

  // Handshake values are stable at the falling edge, the beat moves on the next rise
  always @(negedge s_axis_aclk) begin : out_monitor
    beat_t got;
    int    idx;
    if (m_axis_tvalid === 1'b1 && m_axis_tready === 1'b1) begin
      got.data = m_axis_tdata;
      got.keep = m_axis_tkeep;
      got.last = m_axis_tlast;
      idx      = expected_index(out_cnt);
      if (idx >= sent_q.size()) begin
        $display("Output beat %0d appeared before input beat %0d was accepted", out_cnt, idx);
        errors++;
      end else begin
        check_beat(out_cnt, got, sent_q[idx]);
      end
      out_cnt++;
    end
  end

  always @(posedge s_axis_aclk) begin
    case (ready_mode)
      0:       m_axis_tready <= 1'b0;
      1:       m_axis_tready <= 1'b1;
      default: m_axis_tready <= ($random(ready_seed) & 3) != 0;  // Low about 1 in 4
    endcase
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // Offers n beats, each held until taken
  task automatic send_beats(input int n, input int gap_pct, input bit same_data);
    beat_t cur;
    bit    hs;
    int    taken;
    hs    = 1'b0;
    taken = 0;
    while (taken < n) begin
      @(posedge s_axis_aclk);
      if (hs) begin
        sent_q.push_back(cur);
        taken++;
      end
      if (taken == n) begin
        s_axis_tvalid <= 1'b0;
      end else if (hs || !s_axis_tvalid) begin
        if (rand_pct() < gap_pct) begin
          s_axis_tvalid <= 1'b0;
        end else begin
          // Sequence number in the upper half eases debugging
          cur.data = same_data ? 64'h0123_4567_89ab_cdef : {32'(beat_seq), 32'($random(seed))};
          cur.keep = keep_w'($random(seed));
          cur.last = 1'($random(seed));
          beat_seq++;
          s_axis_tvalid <= 1'b1;
          s_axis_tdata  <= cur.data;
          s_axis_tkeep  <= cur.keep;
          s_axis_tlast  <= cur.last;
        end
      end
      @(negedge s_axis_aclk);
      hs = s_axis_tvalid & s_axis_tready;
      if (s_axis_tvalid && !s_axis_tready) begin
        stall_cnt++;  // Input held off
      end
    end
  endtask

  task automatic set_ready_mode(input int mode);
    @(negedge s_axis_aclk);
    ready_mode = mode;
  endtask

  // Every accepted beat out, then nothing further
  task automatic wait_drain();
    while (out_cnt < sent_q.size()) begin
      @(posedge s_axis_aclk);
    end
    repeat (4 * out_depth) @(posedge s_axis_aclk);
    @(negedge s_axis_aclk);
    check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
    if (out_cnt != sent_q.size()) begin
      $display("Output beat count %0d does not match %0d accepted beats", out_cnt, sent_q.size());
      errors++;
    end
    @(posedge s_axis_aclk);
  endtask

  task automatic report_test(input int num, input string label, input int base);
    $display("Test %0d %s: %0d errors, %0d beats accepted, %0d beats out",
             num, label, errors - base, sent_q.size(), out_cnt);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    int base;
    int stall_base;
    repeat (8) @(posedge s_axis_aclk);
    rst <= 1'b0;
    @(negedge s_axis_aclk);
    check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_bit("s_axis_tready", s_axis_tready, 1'b0);  // Ready is registered
    @(negedge s_axis_aclk);
    check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_bit("s_axis_tready", s_axis_tready, 1'b1);
    @(posedge s_axis_aclk);
    report_test(1, "reset values", 0);

    base = errors;
    send_beats(3 * block_len, 0, 1'b0);
    wait_drain();
    report_test(2, "three blocks back to back", base);

    // Same data on every beat, so only keep and last tell them apart
    base = errors;
    send_beats(block_len, 0, 1'b1);
    wait_drain();
    report_test(3, "keep and last follow their beat", base);

    base = errors;
    set_ready_mode(2);
    send_beats(4 * block_len, 30, 1'b0);
    wait_drain();
    set_ready_mode(1);
    report_test(4, "random gaps and output stalls", base);

    base       = errors;
    stall_base = stall_cnt;
    set_ready_mode(0);
    fork
      send_beats(3 * block_len, 0, 1'b0);
      begin
        repeat (hold_cycles) @(posedge s_axis_aclk);
        set_ready_mode(1);
      end
    join
    wait_drain();
    if (stall_cnt == stall_base) begin
      $display("s_axis_tready never dropped while m_axis_tready was held low");
      errors++;
    end
    report_test(5, "long output back-pressure", base);

    $display("Tests run: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("Timeout: run still busy after %0d clock cycles", watchdog_cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: interleave_top.sv
// Block interleaver top level
// AXI-stream in and out; input beats fill eight banks in bursts of 16,
// the reader takes one beat per bank in turn into a small output FIFO
`timescale 1ns/1ps
`default_nettype none

module interleave_top import interleave_pkg::*; (
  input  logic              s_axis_aclk,
  input  logic              rst,
  input  logic              s_axis_tvalid,
  output logic              s_axis_tready,
  input  logic [data_w-1:0] s_axis_tdata,
  input  logic [keep_w-1:0] s_axis_tkeep,
  input  logic              s_axis_tlast,
  output logic              m_axis_tvalid,
  input  logic              m_axis_tready,
  output logic [data_w-1:0] m_axis_tdata,
  output logic [keep_w-1:0] m_axis_tkeep,
  output logic              m_axis_tlast
);

  beat_t in_beat;
  beat_t rd_beat;   // Reader to output FIFO
  beat_t out_beat;
  logic  rd_valid;
  logic  prog_full;

  bank_if bank_bus ();

  // Slave fields into one beat
  assign in_beat.data = s_axis_tdata;
  assign in_beat.keep = s_axis_tkeep;
  assign in_beat.last = s_axis_tlast;

  interleave_writer u_writer (
    .s_axis_aclk (s_axis_aclk),
    .rst         (rst),
    .in_valid    (s_axis_tvalid),
    .in_ready    (s_axis_tready),
    .in_beat     (in_beat),
    .banks       (bank_bus.writer)
  );

  //////////////////////////////
  // Bank array
  //////////////////////////////
  for (genvar i = 0; i < bank_count; i++) begin : g_bank
    bank_fifo u_bank (
      .s_axis_aclk (s_axis_aclk),
      .rst         (rst),
      .enq         (bank_bus.enq[i]),
      .wdata       (bank_bus.wdata),
      .deq         (bank_bus.deq[i]),
      .rdata       (bank_bus.rdata[i]),
      .afull       (bank_bus.afull[i]),
      .empty       (bank_bus.empty[i])
    );
  end

  interleave_reader u_reader (
    .s_axis_aclk   (s_axis_aclk),
    .rst           (rst),
    .banks         (bank_bus.reader),
    .out_prog_full (prog_full),
    .out_valid     (rd_valid),
    .out_beat      (rd_beat)
  );

  stream_out_fifo u_out_fifo (
    .s_axis_aclk (s_axis_aclk),
    .rst         (rst),
    .wr_valid    (rd_valid),
    .wr_beat     (rd_beat),
    .prog_full   (prog_full),
    .m_valid     (m_axis_tvalid),
    .m_ready     (m_axis_tready),
    .m_beat      (out_beat)
  );

  // Master fields from the head beat
  assign m_axis_tdata = out_beat.data;
  assign m_axis_tkeep = out_beat.keep;
  assign m_axis_tlast = out_beat.last;

endmodule

`default_nettype wire

// File: stream_out_fifo.sv
// Output FIFO of the interleaver
// First-word-fall-through buffer for the reordered stream; the head beat
// is valid whenever the FIFO holds data, prog_full throttles the reader
`timescale 1ns/1ps
`default_nettype none

module stream_out_fifo import interleave_pkg::*; (
  input  logic  s_axis_aclk,
  input  logic  rst,
  input  logic  wr_valid,
  input  beat_t wr_beat,
  output logic  prog_full,
  output logic  m_valid,
  input  logic  m_ready,
  output beat_t m_beat
);

  beat_t mem [out_depth];

  logic [$clog2(out_depth)-1:0] wr_ptr;
  logic [$clog2(out_depth)-1:0] rd_ptr;
  logic [$clog2(out_depth):0]   count;
  logic                         pop;

  assign pop = m_valid & m_ready;

  //////////////////////////////
  // Pointers, count and flag
  //////////////////////////////
  always_ff @(posedge s_axis_aclk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      prog_full <= 1'b0;
    end else begin
      if (wr_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop)      rd_ptr <= rd_ptr + 1'b1;
      case ({wr_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      prog_full <= (count >= out_prog_full_level);  // One cycle behind count
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////
  always_ff @(posedge s_axis_aclk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  // Head beat falls through, valid the cycle after the first write
  assign m_valid = (count != '0);
  assign m_beat  = mem[rd_ptr];

  // Twelve entries plus the reader's two in flight still fit in the
  // sixteen slots, so the writer side needs no ready

endmodule

`default_nettype wire

// File: interleave_reader.sv
// Interleaver read side
// Walks the banks in rotation and takes one beat from each, stalling on an
// empty bank or a nearly full output FIFO; the beat goes out registered
`timescale 1ns/1ps
`default_nettype none

module interleave_reader import interleave_pkg::*; (
  input  logic  s_axis_aclk,
  input  logic  rst,
  bank_if.reader banks,
  input  logic  out_prog_full,
  output logic  out_valid,
  output beat_t out_beat
);

  bank_sel_t rd_sel;  // Current bank in the rotation
  logic      take;

  // Wait on this bank rather than skip it
  assign take = ~banks.empty[rd_sel] & ~out_prog_full;

  //////////////////////////////
  // Dequeue strobes
  //////////////////////////////
  always_comb begin
    banks.deq         = '0;
    banks.deq[rd_sel] = take;  // Only the current bank pops
  end

  //////////////////////////////
  // Rotation and valid pulse
  //////////////////////////////
  always_ff @(posedge s_axis_aclk) begin
    if (rst) begin
      rd_sel    <= '0;
      out_valid <= 1'b0;
    end else begin
      if (take) begin
        rd_sel <= rd_sel + 1'b1;  // 7 wraps back to 0
      end
      out_valid <= take;
    end
  end

  // Head entry captured in the same cycle as its pop
  always_ff @(posedge s_axis_aclk) begin
    out_beat <= banks.rdata[rd_sel];
  end

  // With prog_full registered in the output FIFO, up to two beats
  // may still land there after the flag rises

endmodule

`default_nettype wire

// File: interleave_writer.sv
// Interleaver write side
// Registers each accepted beat, counts accepts to pick the target bank
// and enqueues the beat there one cycle later; ready follows bank full-soon
`timescale 1ns/1ps
`default_nettype none

module interleave_writer import interleave_pkg::*; (
  input  logic  s_axis_aclk,
  input  logic  rst,
  input  logic  in_valid,
  output logic  in_ready,
  input  beat_t in_beat,
  bank_if.writer banks
);

  logic [$clog2(block_len)-1:0] acc_cnt;      // Position inside the block
  logic [$clog2(block_len)-1:0] acc_cnt_next;
  logic                         accept;
  bank_sel_t                    cur_sel;
  bank_sel_t                    next_sel;

  // Stage 1 registers
  beat_t     d1_beat;
  logic      d1_valid;
  bank_sel_t d1_sel;

  assign accept       = in_valid & in_ready;
  assign acc_cnt_next = acc_cnt + accept;  // Wraps after block_len

  // Bank advances every burst_len accepts
  assign cur_sel  = bank_sel_t'(acc_cnt / burst_len);
  assign next_sel = bank_sel_t'(acc_cnt_next / burst_len);

  //////////////////////////////
  // Control
  //////////////////////////////
  always_ff @(posedge s_axis_aclk) begin
    if (rst) begin
      acc_cnt   <= '0;
      d1_valid  <= 1'b0;
      in_ready  <= 1'b0;
      banks.enq <= '0;
    end else begin
      acc_cnt   <= acc_cnt_next;
      d1_valid  <= accept;
      in_ready  <= ~banks.afull[next_sel];  // Bank of the next accept
      banks.enq <= d1_valid ? (bank_count'(1) << d1_sel) : '0;
    end
  end

  //////////////////////////////
  // Payload pipeline
  //////////////////////////////
  always_ff @(posedge s_axis_aclk) begin
    d1_beat     <= in_beat;
    d1_sel      <= cur_sel;
    banks.wdata <= d1_beat;  // Stage 2, lines up with enq
  end

endmodule

`default_nettype wire

// File: bank_fifo.sv
// Bank FIFO
// Single-clock circular buffer holding one bank of the interleaver,
// with the head entry shown combinationally and count-based flags
`timescale 1ns/1ps
`default_nettype none

module bank_fifo import interleave_pkg::*; (
  input  logic  s_axis_aclk,
  input  logic  rst,
  input  logic  enq,
  input  beat_t wdata,
  input  logic  deq,
  output beat_t rdata,
  output logic  afull,
  output logic  empty
);

  beat_t mem [bank_depth];

  logic [$clog2(bank_depth)-1:0] wr_ptr;
  logic [$clog2(bank_depth)-1:0] rd_ptr;
  logic [$clog2(bank_depth):0]   count;   // 0 to bank_depth

  //////////////////////////////
  // Pointers and fill count
  //////////////////////////////
  always_ff @(posedge s_axis_aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq) wr_ptr <= wr_ptr + 1'b1;  // Wraps at bank_depth
      if (deq) rd_ptr <= rd_ptr + 1'b1;
      case ({enq, deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////
  // Storage
  //////////////////////////////
  always_ff @(posedge s_axis_aclk) begin
    if (enq) begin
      mem[wr_ptr] <= wdata;
    end
  end

  assign rdata = mem[rd_ptr];

  // Flags
  assign empty = (count == '0);

  // Write landing this cycle already counts toward the level, which
  // covers the beats still in the writer pipeline
  assign afull = (count + enq) >= bank_afull_level;

endmodule

`default_nettype wire

// File: bank_if.sv
// Bank bus of the interleaver
// Shared write beat plus per-bank enqueue, dequeue, head data and flags
`timescale 1ns/1ps
`default_nettype none

interface bank_if import interleave_pkg::*; ();

  // Write side, one beat broadcast to all banks
  beat_t                 wdata;
  logic [bank_count-1:0] enq;
  logic [bank_count-1:0] afull;

  // Read side
  beat_t                 rdata [bank_count]; // Head entry of each bank
  logic [bank_count-1:0] deq;
  logic [bank_count-1:0] empty;

  modport writer (
    output wdata, enq,
    input  afull
  );

  modport reader (
    output deq,
    input  rdata, empty
  );

  // Bank side of the bus
  modport store (
    input  wdata, enq, deq,
    output rdata, afull, empty
  );

endinterface

`default_nettype wire

// File: interleave_pkg.sv
// Block interleaver shared definitions
// Stream widths, bank geometry, FIFO thresholds and the beat type that
// carries data, keep and last together through every stage
`default_nettype none

package interleave_pkg;

  //////////////////////////////
  // Stream widths
  //////////////////////////////
  localparam int data_w = 64;
  localparam int keep_w = data_w / 8;

  //////////////////////////////
  // Bank geometry
  //////////////////////////////
  localparam int bank_count = 8;
  localparam int burst_len  = 16;                     // Beats per bank per block
  localparam int block_len  = bank_count * burst_len; // 128 beats
  localparam int bank_depth = 32;

  // Writer pipeline can still push after the flag
  localparam int bank_afull_level = bank_depth - 2;

  //////////////////////////////
  // Output FIFO
  //////////////////////////////
  localparam int out_depth           = 16;
  localparam int out_prog_full_level = out_depth - 4; // Reader has two beats in flight

  // One stream beat, 73 bits
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [keep_w-1:0] keep;
    logic              last;
  } beat_t;

  typedef logic [$clog2(bank_count)-1:0] bank_sel_t;

endpackage

`default_nettype wire
